// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_fir_serial
FILELIST  := fir_serial.f
OBJ_DIR   := obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== carry_select_adder.sv ====
`timescale 1ns/10ps

module carry_select_adder (
  input  fir_pkg::acc_t a,
  input  fir_pkg::acc_t b,
  output fir_pkg::acc_t sum
);

  import fir_pkg::*;

  logic [csa_num_blocks-1:1] blk_carry;  // carry into each upper block

  for (genvar i = 0; i < csa_num_blocks; i++) begin : g_block
    localparam int lo = csa_block_lo(i);
    localparam int w  = int'(csa_block_w[i]);

    logic [w-1:0] p;
    logic [w-1:0] g;
    logic [w:0]   c0;  // chain with carry-in 0
    logic [w-1:0] s0;

    assign p     = a[lo +: w] ^ b[lo +: w];
    assign g     = a[lo +: w] & b[lo +: w];
    assign c0[0] = 1'b0;

    for (genvar j = 0; j < w; j++) begin : g_bit0
      assign c0[j+1] = g[j] | (p[j] & c0[j]);
    end

    assign s0 = p ^ c0[w-1:0];

    if (i == 0) begin : g_ripple
      // plain ripple block at the bottom
      assign sum[lo +: w] = s0;
      assign blk_carry[1] = c0[w];
    end else begin : g_select
      logic [w:0]   c1;  // chain with carry-in 1
      logic [w-1:0] s1;

      assign c1[0] = 1'b1;

      for (genvar j = 0; j < w; j++) begin : g_bit1
        assign c1[j+1] = g[j] | (p[j] & c1[j]);
      end

      assign s1 = p ^ c1[w-1:0];

      assign sum[lo +: w] = blk_carry[i] ? s1 : s0;

      // top carry out is dropped, sum wraps
      if (i < csa_num_blocks - 1) begin : g_carry
        assign blk_carry[i+1] = blk_carry[i] ? c1[w] : c0[w];
      end
    end
  end

endmodule

// ==== fir_delay_line.sv ====
`timescale 1ns/10ps

module fir_delay_line (
  input  logic               clk,
  input  logic               reset,
  input  fir_pkg::sample_t   filter_in,
  input  fir_pkg::phase_t    phase,
  output fir_pkg::part_ops_t ops
);

  import fir_pkg::*;

  sample_t [num_taps-1:0] taps;  // taps[0] is x[n]
  step_t                  sel;

  ////////////////////////////////////////////////////////////////////////////
  // sample shift register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      taps <= '0;
    end else if (phase.shift) begin
      taps <= {taps[num_taps-2:0], filter_in};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // operand select, one tap per partition per step
  ////////////////////////////////////////////////////////////////////////////

  // shift step reuses the last tap slot
  always_comb begin
    if (phase.step >= step_t'(taps_per_part)) begin
      sel = step_t'(taps_per_part - 1);
    end else begin
      sel = phase.step;
    end
  end

  always_comb begin
    for (int p = 0; p < num_parts; p++) begin
      ops[p] = taps[p * taps_per_part + int'(sel)];
    end
  end

endmodule

// ==== fir_frame_ctrl.sv ====
`timescale 1ns/10ps

module fir_frame_ctrl (
  input  logic            clk,
  input  logic            reset,
  input  logic            clk_enable,
  output fir_pkg::phase_t phase
);

  import fir_pkg::*;

  step_t step;

  // 4, 0, 1, 2, 3, 4 ... one step per enabled clock
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      step <= shift_step;  // first enabled cycle shifts
    end else if (clk_enable) begin
      if (step >= shift_step) begin
        step <= '0;
      end else begin
        step <= step + step_t'(1);
      end
    end
  end

  // phase flags already carry the enable
  always_comb begin
    phase.step  = step;
    phase.shift = clk_enable && (step == shift_step);
    phase.first = clk_enable && (step == '0);
    phase.mac   = clk_enable && (step < shift_step);
  end

endmodule

// ==== fir_mac_partition.sv ====
`timescale 1ns/10ps

module fir_mac_partition #(
  parameter int part_index = 0
) (
  input  logic             clk,
  input  logic             reset,
  input  fir_pkg::phase_t  phase,
  input  fir_pkg::sample_t sample,
  output fir_pkg::acc_t    partial
);

  import fir_pkg::*;

  step_t                                 sel;
  coeff_t                                coeff;
  logic signed [sample_w+coeff_w-1:0]    full_product;  // Q1.31
  product_t                              product;
  acc_t                                  product_ext;
  acc_t                                  acc_sum;
  acc_t                                  acc;

  ////////////////////////////////////////////////////////////////////////////
  // coefficient select and multiply
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (phase.step >= step_t'(taps_per_part)) begin
      sel = step_t'(taps_per_part - 1);
    end else begin
      sel = phase.step;
    end
  end

  assign coeff        = coeffs[part_index * taps_per_part + int'(sel)];
  assign full_product = sample * coeff;
  assign product      = full_product[product_w-1:0];  // top bit is redundant
  assign product_ext  = {{(acc_w - product_w){product[product_w-1]}}, product};

  ////////////////////////////////////////////////////////////////////////////
  // accumulator
  ////////////////////////////////////////////////////////////////////////////

  carry_select_adder u_acc_add (
    .a   (acc),
    .b   (product_ext),
    .sum (acc_sum)
  );

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      acc <= '0;
    end else if (phase.first) begin
      acc <= product_ext;  // new frame
    end else if (phase.mac) begin
      acc <= acc_sum;
    end
  end

  assign partial = acc;  // valid after step 3

endmodule

// ==== fir_output_stage.sv ====
`timescale 1ns/10ps

module fir_output_stage (
  input  logic            clk,
  input  logic            reset,
  input  fir_pkg::phase_t phase,
  input  fir_pkg::acc_t   partial_0,
  input  fir_pkg::acc_t   partial_1,
  output fir_pkg::acc_t   filter_out
);

  import fir_pkg::*;

  acc_t frame_sum;

  carry_select_adder u_final_add (
    .a   (partial_0),
    .b   (partial_1),
    .sum (frame_sum)
  );

  // both partials are complete on the shift cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      filter_out <= '0;
    end else if (phase.shift) begin
      filter_out <= frame_sum;  // y[n], held for a frame
    end
  end

endmodule

// ==== fir_pkg.sv ====
package fir_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and fixed-point formats
  ////////////////////////////////////////////////////////////////////////////

  localparam int sample_w  = 16;  // Q1.15
  localparam int coeff_w   = 16;  // Q0.16
  localparam int product_w = 31;  // Q0.31, top sign bit dropped
  localparam int acc_w     = 33;  // Q2.31
  localparam int step_w    = 3;

  typedef logic signed [sample_w-1:0]  sample_t;
  typedef logic signed [coeff_w-1:0]   coeff_t;
  typedef logic signed [product_w-1:0] product_t;
  typedef logic signed [acc_w-1:0]     acc_t;
  typedef logic [step_w-1:0]           step_t;

  ////////////////////////////////////////////////////////////////////////////
  // filter structure
  ////////////////////////////////////////////////////////////////////////////

  localparam int num_taps      = 8;
  localparam int num_parts     = 2;
  localparam int taps_per_part = num_taps / num_parts;
  localparam int frame_len     = taps_per_part + 1;  // four mac steps, one shift
  localparam step_t shift_step = step_t'(frame_len - 1);

  // symmetric taps, index 0 multiplies the newest sample
  localparam coeff_t [0:num_taps-1] coeffs = {
    16'hddbb, 16'hea8e, 16'h33db, 16'h6808,
    16'h6808, 16'h33db, 16'hea8e, 16'hddbb
  };

  // carry-select adder blocks, lsb first
  localparam int csa_num_blocks = 4;
  localparam logic [0:csa_num_blocks-1][5:0] csa_block_w = {6'd5, 6'd7, 6'd9, 6'd12};

  // low bit position of an adder block
  function automatic int csa_block_lo(input int idx);
    int lo;
    lo = 0;
    for (int i = 0; i < idx; i++) begin
      lo += int'(csa_block_w[i]);
    end
    return lo;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // shared bundles
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    step_t step;   // raw frame step
    logic  shift;  // enabled step 4
    logic  first;  // enabled step 0
    logic  mac;    // enabled steps 0..3
  } phase_t;

  typedef sample_t [num_parts-1:0] part_ops_t;

endpackage

// ==== fir_serial.f ====
+incdir+.
fir_pkg.sv
carry_select_adder.sv
fir_frame_ctrl.sv
fir_delay_line.sv
fir_mac_partition.sv
fir_output_stage.sv
fir_serial_top.sv
tb_fir_serial.sv

// ==== fir_serial_top.sv ====
`timescale 1ns/10ps

module fir_serial_top (
  input  logic             clk,
  input  logic             reset,
  input  logic             clk_enable,
  input  fir_pkg::sample_t filter_in,
  output fir_pkg::acc_t    filter_out,
  output logic             frame_strobe
);

  import fir_pkg::*;

  phase_t    phase;
  part_ops_t ops;
  acc_t      partial_0;
  acc_t      partial_1;

  ////////////////////////////////////////////////////////////////////////////
  // frame timing and sample storage
  ////////////////////////////////////////////////////////////////////////////

  fir_frame_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .phase      (phase)
  );

  fir_delay_line u_delay (
    .clk       (clk),
    .reset     (reset),
    .filter_in (filter_in),
    .phase     (phase),
    .ops       (ops)
  );

  ////////////////////////////////////////////////////////////////////////////
  // two mac partitions and the final sum
  ////////////////////////////////////////////////////////////////////////////

  fir_mac_partition #(.part_index(0)) u_part_0 (
    .clk     (clk),
    .reset   (reset),
    .phase   (phase),
    .sample  (ops[0]),
    .partial (partial_0)
  );

  fir_mac_partition #(.part_index(1)) u_part_1 (
    .clk     (clk),
    .reset   (reset),
    .phase   (phase),
    .sample  (ops[1]),
    .partial (partial_1)
  );

  fir_output_stage u_out (
    .clk        (clk),
    .reset      (reset),
    .phase      (phase),
    .partial_0  (partial_0),
    .partial_1  (partial_1),
    .filter_out (filter_out)
  );

  assign frame_strobe = phase.shift;  // sample taken on this edge

endmodule

// ==== tb_fir_util.svh ====
`ifndef TB_FIR_UTIL_SVH
`define TB_FIR_UTIL_SVH

////////////////////////////////////////////////////////////////////////////
// random numbers
////////////////////////////////////////////////////////////////////////////

logic [31:0] lcg_state = 32'hfc18_0a37;

function automatic logic [31:0] next_random();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// random sample with runs of full scale values
function automatic sample_t pick_sample(input int i);
  logic [31:0] r;
  r = next_random();
  if ((i >= 40 && i < 48) || i % 23 == 3) begin
    return 16'h8000;
  end else if ((i >= 100 && i < 108) || i % 29 == 5) begin
    return 16'h7fff;
  end else if (i >= 150 && i < 158) begin
    return (i % 2 == 0) ? 16'h8000 : 16'h7fff;  // alternating extremes
  end
  return r[31:16];
endfunction

////////////////////////////////////////////////////////////////////////////
// golden model of y[n] = sum of weight[k] * x[n-k]
////////////////////////////////////////////////////////////////////////////

localparam coeff_t tap_weights [0:7] = '{
  16'hddbb, 16'hea8e, 16'h33db, 16'h6808,
  16'h6808, 16'h33db, 16'hea8e, 16'hddbb
};

sample_t history [0:7];  // history[0] is newest
acc_t    expected_out;   // y of the sample before the newest

function automatic void reset_model();
  for (int k = 0; k < 8; k++) begin
    history[k] = '0;
  end
  expected_out = '0;
endfunction

function automatic acc_t golden_output();
  longint total;
  total = 0;
  for (int k = 0; k < 8; k++) begin
    total += longint'(tap_weights[k]) * longint'(history[k]);
  end
  return acc_t'(total);
endfunction

function automatic void push_sample(input sample_t x);
  for (int k = 7; k > 0; k--) begin
    history[k] = history[k-1];
  end
  history[0] = x;
endfunction

////////////////////////////////////////////////////////////////////////////
// sample drive
////////////////////////////////////////////////////////////////////////////

localparam int frame_timeout = 200;  // cycles

int stall_pct = 0;  // percent chance of a low clk_enable

task automatic set_enable();
  if (stall_pct == 0) begin
    clk_enable <= 1'b1;
  end else begin
    clk_enable <= (next_random() % 100) >= stall_pct;
  end
endtask

// starts just after a rising edge and returns just after the capture edge
task automatic present_sample(input sample_t x);
  int waited;
  filter_in <= x;
  waited = 0;
  @(negedge clk);
  while (!frame_strobe) begin
    if (waited >= frame_timeout) begin
      abort_run("frame_strobe did not arrive within the timeout");
    end
    @(posedge clk);
    set_enable();
    @(negedge clk);
    waited++;
  end
  @(posedge clk);
  expected_out = golden_output();  // previous y appears after this edge
  push_sample(x);
  set_enable();
endtask

`endif

// ==== tb_fir_serial.sv ====
`timescale 1ns/10ps

module tb_fir_serial;

  import fir_pkg::*;

  localparam int frame_cycles = 5;

  logic    clk;
  logic    reset;
  logic    clk_enable;
  sample_t filter_in;
  acc_t    filter_out;
  logic    frame_strobe;

  int   enabled_cycles;  // since reset
  acc_t last_out;
  logic last_stalled;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  `include "tb_fir_util.svh"

  fir_serial_top dut0 (
    .clk          (clk),
    .reset        (reset),
    .clk_enable   (clk_enable),
    .filter_in    (filter_in),
    .filter_out   (filter_out),
    .frame_strobe (frame_strobe)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  assert property (@(posedge clk) disable iff (reset) !clk_enable |-> !frame_strobe)
    else abort_run($sformatf("Fail frame_strobe: got %h, expected 0",
                             $sampled(frame_strobe)));

  // y of the previous sample after every shift edge
  assert property (@(posedge clk) disable iff (reset)
                   frame_strobe |=> filter_out == expected_out)
    else abort_run($sformatf("Fail filter_out: got %h, expected %h",
                             $sampled(filter_out), $sampled(expected_out)));

  // one strobe per five enabled cycles from the first one
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      enabled_cycles <= 0;
    end else if (clk_enable) begin
      assert (frame_strobe == (enabled_cycles % frame_cycles == 0))
        else abort_run($sformatf("Fail frame_strobe: got %h, expected %h", frame_strobe,
                                 enabled_cycles % frame_cycles == 0));
      enabled_cycles <= enabled_cycles + 1;
    end
  end

  // a stalled edge must leave filter_out alone
  always @(posedge clk or posedge reset) begin
    if (reset) begin
      last_stalled <= 1'b0;
      last_out     <= '0;
    end else begin
      if (last_stalled) begin
        assert (filter_out == last_out)
          else abort_run($sformatf("Fail filter_out: got %h, expected %h", filter_out,
                                   last_out));
      end
      last_stalled <= !clk_enable;
      last_out     <= filter_out;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply_reset();
    reset      <= 1'b1;
    clk_enable <= 1'b0;
    reset_model();
    repeat (2) @(posedge clk);
    reset <= 1'b0;
  endtask

  function automatic acc_t impulse_value(input int n);
    acc_t value;
    value = '0;
    for (int k = 0; k < 8; k++) begin
      if (k == n) begin
        value = acc_t'(longint'(tap_weights[k]) * 64'sd16384);  // x 16'h4000
      end
    end
    return value;
  endfunction

  initial begin
    acc_t impulse;
    reset      = 1'b1;
    clk_enable = 1'b0;
    filter_in  = '0;
    apply_reset();

    // idle after reset
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      assert (filter_out == '0)
        else abort_run($sformatf("Fail filter_out: got %h, expected 0", filter_out));
      assert (!frame_strobe)
        else abort_run($sformatf("Fail frame_strobe: got %h, expected 0", frame_strobe));
    end
    @(posedge clk);

    // frame spacing on a zero stream
    for (int i = 0; i < 6; i++) begin
      present_sample('0);
    end

    // impulse response
    for (int i = 0; i < 11; i++) begin
      present_sample(i == 0 ? 16'h4000 : 16'h0000);
      if (i >= 1) begin
        @(negedge clk);
        impulse = impulse_value(i - 1);
        assert (filter_out == impulse)
          else abort_run($sformatf("Fail filter_out: got %h, expected %h", filter_out,
                                   impulse));
        @(posedge clk);
      end
    end

    for (int i = 0; i < 200; i++) begin
      present_sample(pick_sample(i));
    end

    stall_pct = 35;  // random gaps in clk_enable
    for (int i = 0; i < 120; i++) begin
      present_sample(pick_sample(i));
    end

    // reset in the middle of a stalled stream
    stall_pct = 20;
    for (int i = 0; i < 40; i++) begin
      present_sample(pick_sample(i + 60));
    end
    apply_reset();
    assert (filter_out == '0)
      else abort_run($sformatf("Fail filter_out: got %h, expected 0", filter_out));
    for (int i = 0; i < 40; i++) begin
      present_sample(pick_sample(i + 140));
    end

    $display("Everything OK");
    $finish;
  end

endmodule
